// ==== verilog/game_pkg.sv ====
package game_pkg;

    //////////////////////////////
    // Board size and widths
    //////////////////////////////

    localparam int MAX_CARDS = 64;
    localparam int ADDR_W    = $clog2(MAX_CARDS);
    // Two cards per colour
    localparam int COLOR_W   = ADDR_W - 1;
    localparam int SEC_W     = 8;

    //////////////////////////////
    // Cards
    //////////////////////////////

    typedef enum logic [1:0] {
        CARD_HIDDEN,
        CARD_SHOWN,
        CARD_MATCHED
    } card_state_e;

    typedef struct packed {
        logic [COLOR_W-1:0] color;
        card_state_e        state;
    } card_t;

    //////////////////////////////
    // Command channel
    //////////////////////////////

    typedef enum logic {
        CMD_NEW_GAME,
        CMD_CLICK
    } cmd_op_e;

    // Key only matters for a new game
    typedef struct packed {
        cmd_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] key;
    } cmd_t;

    typedef enum logic [2:0] {
        RES_NONE,
        RES_FIRST,
        RES_MATCH,
        RES_MISS,
        RES_IGNORED,
        RES_DEALT
    } result_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PLAYING,
        PH_WON,
        PH_LOST
    } game_phase_e;

    typedef struct packed {
        game_phase_e       phase;
        result_e           result;
        logic [ADDR_W-1:0] pairs;
        logic [SEC_W-1:0]  seconds;
    } status_t;

endpackage

// ==== verilog/card_board.sv ====
`timescale 1ns/1ps

module card_board #(
    parameter int NUM_CARDS = 16
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        deal_start,
    input  logic [game_pkg::ADDR_W-1:0] deal_key,
    output logic                        deal_busy,
    input  logic [game_pkg::ADDR_W-1:0] play_addr,
    input  logic                        play_we,
    input  game_pkg::card_state_e       play_state,
    output game_pkg::card_t             play_card,
    input  logic [game_pkg::ADDR_W-1:0] view_addr,
    output game_pkg::card_t             view_card
);

    import game_pkg::*;

    localparam int IDX_W = $clog2(NUM_CARDS);

    card_t            board [NUM_CARDS];
    logic [IDX_W-1:0] deal_idx;
    logic [IDX_W-1:0] key_q;
    logic [IDX_W-1:0] deal_sum;
    card_t            deal_card;

    //////////////////////////////
    // Deal colour
    //////////////////////////////

    // Sum wraps at NUM_CARDS, halving gives each colour to two slots
    assign deal_sum = deal_idx + key_q;

    always_comb begin
        deal_card.color = COLOR_W'(deal_sum >> 1);
        deal_card.state = CARD_HIDDEN;
    end

    //////////////////////////////
    // Slots and deal sequencer
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_CARDS; i++) begin
                board[i] <= '0;
            end
            deal_busy <= 1'b0;
            deal_idx  <= '0;
            key_q     <= '0;
        end else if (deal_busy) begin
            // One slot per cycle
            board[deal_idx] <= deal_card;
            deal_idx        <= deal_idx + 1'b1;
            if (deal_idx == IDX_W'(NUM_CARDS - 1)) begin
                deal_busy <= 1'b0;
            end
        end else if (deal_start) begin
            deal_busy <= 1'b1;
            deal_idx  <= '0;
            key_q     <= deal_key[IDX_W-1:0];
        end else if (play_we) begin
            // Colour stays, only the state moves
            board[play_addr[IDX_W-1:0]].state <= play_state;
        end
    end

    // Registered read ports
    always_ff @(posedge clk) begin
        play_card <= board[play_addr[IDX_W-1:0]];
        view_card <= board[view_addr[IDX_W-1:0]];
    end

endmodule

// ==== verilog/game_timer.sv ====
`timescale 1ns/1ps

module game_timer #(
    parameter int TICKS_PER_SEC = 65_000_000,
    parameter int TIME_LIMIT    = 60
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       clear,
    input  logic                       run,
    output logic [game_pkg::SEC_W-1:0] seconds,
    output logic                       time_up
);

    import game_pkg::*;

    localparam int PRE_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

    logic [PRE_W-1:0] prescale;
    logic             sec_tick;

    // Last cycle of the current second
    assign sec_tick = (prescale == PRE_W'(TICKS_PER_SEC - 1));

    assign time_up = (seconds == SEC_W'(TIME_LIMIT));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale <= '0;
            seconds  <= '0;
        end else if (clear) begin
            prescale <= '0;
            seconds  <= '0;
        end else if (run && !time_up) begin
            // Counter holds once the limit is reached
            if (sec_tick) begin
                prescale <= '0;
                seconds  <= seconds + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm #(
    parameter int NUM_CARDS = 16
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  game_pkg::cmd_t              cmd,
    input  logic                        cmd_req,
    output logic                        cmd_ack,
    output game_pkg::status_t           status,
    output logic                        deal_start,
    output logic [game_pkg::ADDR_W-1:0] deal_key,
    input  logic                        deal_busy,
    output logic [game_pkg::ADDR_W-1:0] play_addr,
    output logic                        play_we,
    output game_pkg::card_state_e       play_state,
    input  game_pkg::card_t             play_card,
    output logic                        timer_clear,
    output logic                        timer_run,
    input  logic [game_pkg::SEC_W-1:0]  seconds,
    input  logic                        time_up
);

    import game_pkg::*;

    typedef enum logic [2:0] {
        S_WAIT_REQ,
        S_DEAL,
        S_READ,
        S_DECIDE,
        S_PARTNER,
        S_ACK,
        S_WAIT_DROP
    } fsm_state_e;

    fsm_state_e         state;
    game_phase_e        phase;
    result_e            result;
    logic [ADDR_W-1:0]  pairs;
    logic               first_valid;
    logic [ADDR_W-1:0]  first_addr;
    logic [COLOR_W-1:0] first_color;
    logic               pair_match;
    logic               click_dead;

    assign pair_match = (play_card.color == first_color);
    // No turn possible once the game is over or the clock ran out
    assign click_dead = (phase != PH_PLAYING) || time_up || (play_card.state != CARD_HIDDEN);

    // Ack stays up until the request drops
    assign cmd_ack   = (state == S_ACK) || (state == S_WAIT_DROP);
    assign timer_run = (phase == PH_PLAYING);
    assign status    = '{phase: phase, result: result, pairs: pairs, seconds: seconds};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_WAIT_REQ;
            phase       <= PH_IDLE;
            result      <= RES_NONE;
            pairs       <= '0;
            first_valid <= 1'b0;
            first_addr  <= '0;
            first_color <= '0;
            deal_start  <= 1'b0;
            deal_key    <= '0;
            play_addr   <= '0;
            play_we     <= 1'b0;
            play_state  <= CARD_HIDDEN;
            timer_clear <= 1'b0;
        end else begin
            // Pulses
            deal_start  <= 1'b0;
            timer_clear <= 1'b0;
            play_we     <= 1'b0;

            // Loss on time, even between commands
            if (phase == PH_PLAYING && time_up) begin
                phase <= PH_LOST;
            end

            case (state)
                S_WAIT_REQ: begin
                    if (cmd_req) begin
                        if (cmd.op == CMD_NEW_GAME) begin
                            deal_start  <= 1'b1;
                            deal_key    <= cmd.key;
                            timer_clear <= 1'b1;
                            phase       <= PH_IDLE;
                            pairs       <= '0;
                            first_valid <= 1'b0;
                            state       <= S_DEAL;
                        end else begin
                            play_addr <= cmd.addr;
                            state     <= S_READ;
                        end
                    end
                end
                S_DEAL: begin
                    // deal_busy only rises the cycle after the start pulse
                    if (!deal_start && !deal_busy) begin
                        phase  <= PH_PLAYING;
                        result <= RES_DEALT;
                        state  <= S_ACK;
                    end
                end
                S_READ: begin
                    state <= S_DECIDE;
                end
                S_DECIDE: begin
                    if (click_dead) begin
                        result <= RES_IGNORED;
                        state  <= S_ACK;
                    end else if (!first_valid) begin
                        play_we     <= 1'b1;
                        play_state  <= CARD_SHOWN;
                        first_valid <= 1'b1;
                        first_addr  <= play_addr;
                        first_color <= play_card.color;
                        result      <= RES_FIRST;
                        state       <= S_ACK;
                    end else begin
                        // Second card of the turn, written now
                        play_we     <= 1'b1;
                        first_valid <= 1'b0;
                        state       <= S_PARTNER;
                        if (pair_match) begin
                            play_state <= CARD_MATCHED;
                            pairs      <= pairs + 1'b1;
                            result     <= RES_MATCH;
                            if (pairs == ADDR_W'(NUM_CARDS / 2 - 1)) begin
                                phase <= PH_WON;
                            end
                        end else begin
                            play_state <= CARD_HIDDEN;
                            result     <= RES_MISS;
                        end
                    end
                end
                S_PARTNER: begin
                    // Same new state for the first card
                    play_addr <= first_addr;
                    play_we   <= 1'b1;
                    state     <= S_ACK;
                end
                S_ACK: begin
                    state <= S_WAIT_DROP;
                end
                S_WAIT_DROP: begin
                    if (!cmd_req) begin
                        state <= S_WAIT_REQ;
                    end
                end
                default: begin
                    state <= S_WAIT_REQ;
                end
            endcase
        end
    end

endmodule

// ==== verilog/memory_core.sv ====
`timescale 1ns/1ps

module memory_core #(
    parameter int NUM_CARDS     = 16,
    parameter int TICKS_PER_SEC = 65_000_000,
    parameter int TIME_LIMIT    = 60
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  game_pkg::cmd_t              cmd,
    input  logic                        cmd_req,
    output logic                        cmd_ack,
    output game_pkg::status_t           status,
    input  logic [game_pkg::ADDR_W-1:0] view_addr,
    output game_pkg::card_t             view_card
);

    import game_pkg::*;

    // Board side
    logic              deal_start;
    logic [ADDR_W-1:0] deal_key;
    logic              deal_busy;
    logic [ADDR_W-1:0] play_addr;
    logic              play_we;
    card_state_e       play_state;
    card_t             play_card;

    // Timer side
    logic              timer_clear;
    logic              timer_run;
    logic [SEC_W-1:0]  seconds;
    logic              time_up;

    //////////////////////////////
    // Card store
    //////////////////////////////

    card_board #(
        .NUM_CARDS(NUM_CARDS)
    ) u_card_board (
        .clk(clk),
        .arst_n(arst_n),
        .deal_start(deal_start),
        .deal_key(deal_key),
        .deal_busy(deal_busy),
        .play_addr(play_addr),
        .play_we(play_we),
        .play_state(play_state),
        .play_card(play_card),
        .view_addr(view_addr),
        .view_card(view_card)
    );

    //////////////////////////////
    // Stopwatch
    //////////////////////////////

    game_timer #(
        .TICKS_PER_SEC(TICKS_PER_SEC),
        .TIME_LIMIT(TIME_LIMIT)
    ) u_game_timer (
        .clk(clk),
        .arst_n(arst_n),
        .clear(timer_clear),
        .run(timer_run),
        .seconds(seconds),
        .time_up(time_up)
    );

    //////////////////////////////
    // Game control
    //////////////////////////////

    game_fsm #(
        .NUM_CARDS(NUM_CARDS)
    ) u_game_fsm (
        .clk(clk),
        .arst_n(arst_n),
        .cmd(cmd),
        .cmd_req(cmd_req),
        .cmd_ack(cmd_ack),
        .status(status),
        .deal_start(deal_start),
        .deal_key(deal_key),
        .deal_busy(deal_busy),
        .play_addr(play_addr),
        .play_we(play_we),
        .play_state(play_state),
        .play_card(play_card),
        .timer_clear(timer_clear),
        .timer_run(timer_run),
        .seconds(seconds),
        .time_up(time_up)
    );

endmodule

// ==== verif/tb_game_model.svh ====
`ifndef TB_GAME_MODEL_SVH
`define TB_GAME_MODEL_SVH

// Expected board, phase and pair count
logic [COLOR_W-1:0] exp_color [NUM_CARDS];
card_state_e        exp_state [NUM_CARDS];
game_phase_e        exp_phase;
logic [ADDR_W-1:0]  exp_pairs;
logic               turn_open;
int                 turn_addr;

function automatic void reset_model();
    for (int a = 0; a < NUM_CARDS; a++) begin
        exp_color[a] = '0;
        exp_state[a] = CARD_HIDDEN;
    end
    exp_phase = PH_IDLE;
    exp_pairs = '0;
    turn_open = 1'b0;
    turn_addr = 0;
endfunction

// Colour is ((a + key) mod N) / 2, so each colour lands on two slots
function automatic void deal_board(input int key);
    for (int a = 0; a < NUM_CARDS; a++) begin
        exp_color[a] = COLOR_W'(((a + key) % NUM_CARDS) / 2);
        exp_state[a] = CARD_HIDDEN;
    end
    exp_phase = PH_PLAYING;
    exp_pairs = '0;
    turn_open = 1'b0;
endfunction

function automatic result_e predict_click(input int addr);
    if (exp_phase != PH_PLAYING || exp_state[addr] != CARD_HIDDEN) begin
        return RES_IGNORED;
    end
    if (!turn_open) begin
        exp_state[addr] = CARD_SHOWN;
        turn_open       = 1'b1;
        turn_addr       = addr;
        return RES_FIRST;
    end
    turn_open = 1'b0;
    if (exp_color[addr] == exp_color[turn_addr]) begin
        exp_state[addr]      = CARD_MATCHED;
        exp_state[turn_addr] = CARD_MATCHED;
        exp_pairs            = exp_pairs + 1'b1;
        if (exp_pairs == ADDR_W'(NUM_CARDS / 2)) begin
            exp_phase = PH_WON;
        end
        return RES_MATCH;
    end
    // Miss turns both back over right away
    exp_state[addr]      = CARD_HIDDEN;
    exp_state[turn_addr] = CARD_HIDDEN;
    return RES_MISS;
endfunction

`endif

// ==== verif/tb_memory_core.sv ====
`timescale 1ns/1ps

module tb_memory_core;

    import game_pkg::*;

    localparam int NUM_CARDS       = 16;
    localparam int TICKS_PER_SEC   = 20;
    localparam int TIME_LIMIT      = 6;
    localparam int IDX_W           = $clog2(NUM_CARDS);
    localparam int CLK_PERIOD      = 100;
    // Short random games stay well inside the time limit
    localparam int GAMES           = 6;
    localparam int CLICKS_PER_GAME = 4;
    // Random games, then deal + all clicks + two extra for the win, then three for the loss
    localparam int NUM_CMDS = GAMES * (CLICKS_PER_GAME + 1) + (NUM_CARDS + 3) + 3;
    localparam longint WATCHDOG_NS =
        longint'(NUM_CMDS * (NUM_CARDS + 10) + TIME_LIMIT * TICKS_PER_SEC * 2) * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              arst_n;
    cmd_t              cmd;
    logic              cmd_req;
    logic              cmd_ack;
    status_t           status;
    logic [ADDR_W-1:0] view_addr;
    card_t             view_card;

    logic [31:0] lfsr = 32'h8cbf6adc;
    int          checks = 0;
    int          errors = 0;
    logic        prev_req;
    logic        prev_ack;

    `include "tb_game_model.svh"

    memory_core #(
        .NUM_CARDS(NUM_CARDS),
        .TICKS_PER_SEC(TICKS_PER_SEC),
        .TIME_LIMIT(TIME_LIMIT)
    ) DUT (
        .clk(clk),
        .arst_n(arst_n),
        .cmd(cmd),
        .cmd_req(cmd_req),
        .cmd_ack(cmd_ack),
        .status(status),
        .view_addr(view_addr),
        .view_card(view_card)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Four-phase req/ack, status taken while ack is high
    task automatic run_handshake(input cmd_t c, output status_t st);
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        do @(negedge clk); while (!cmd_ack);
        st = status;
        @(posedge clk);
        cmd_req <= 1'b0;
        do @(negedge clk); while (cmd_ack);
    endtask

    task automatic start_game(input int key);
        cmd_t    c;
        status_t st;
        c.op   = CMD_NEW_GAME;
        c.addr = '0;
        c.key  = ADDR_W'(key);
        run_handshake(c, st);
        deal_board(key);
        check_value("status.result", st.result, RES_DEALT);
        check_value("status.phase", st.phase, exp_phase);
        check_value("status.pairs", st.pairs, exp_pairs);
        check_value("status.seconds", st.seconds, 0);
    endtask

    task automatic click_card(input int addr);
        cmd_t    c;
        status_t st;
        result_e exp_res;
        c.op   = CMD_CLICK;
        c.addr = ADDR_W'(addr);
        c.key  = '0;
        run_handshake(c, st);
        exp_res = predict_click(addr);
        check_value("status.result", st.result, exp_res);
        check_value("status.phase", st.phase, exp_phase);
        check_value("status.pairs", st.pairs, exp_pairs);
    endtask

    // Address pipelined one cycle ahead of the registered read
    task automatic check_view();
        for (int a = 0; a <= NUM_CARDS; a++) begin
            @(posedge clk);
            if (a < NUM_CARDS) begin
                view_addr <= ADDR_W'(a);
            end
            @(negedge clk);
            if (a > 0) begin
                check_value($sformatf("view_card[%0d].color", a - 1), view_card.color,
                            exp_color[a - 1]);
                check_value($sformatf("view_card[%0d].state", a - 1), view_card.state,
                            exp_state[a - 1]);
            end
        end
    endtask

    //////////////////////////////
    // Handshake order monitor
    //////////////////////////////

    always @(negedge clk) begin
        if (!arst_n) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            if (cmd_ack && !prev_ack) begin
                assert (cmd_req) else begin
                    errors++;
                    $display("cmd_ack rose while cmd_req was low at %0t", $time);
                end
            end
            if (!cmd_ack && prev_ack) begin
                assert (!cmd_req) else begin
                    errors++;
                    $display("cmd_ack fell while cmd_req was still high at %0t", $time);
                end
            end
            if (cmd_req && !prev_req) begin
                assert (!cmd_ack) else begin
                    errors++;
                    $display("cmd_ack was already high when a request started at %0t", $time);
                end
            end
            prev_req = cmd_req;
            prev_ack = cmd_ack;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        arst_n    = 1'b0;
        cmd       = '0;
        cmd_req   = 1'b0;
        view_addr = '0;
        reset_model();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // State out of reset
        @(negedge clk);
        check_value("cmd_ack", cmd_ack, 1'b0);
        check_value("status.phase", status.phase, PH_IDLE);
        check_value("status.result", status.result, RES_NONE);
        check_value("status.pairs", status.pairs, 0);
        check_value("status.seconds", status.seconds, 0);
        check_view();

        // Random games
        for (int g = 0; g < GAMES; g++) begin
            start_game(random_bits(ADDR_W));
            check_view();
            for (int k = 0; k < CLICKS_PER_GAME; k++) begin
                click_card(random_bits(IDX_W));
                check_view();
            end
        end

        // Clear the whole board pair by pair
        start_game(random_bits(ADDR_W));
        for (int c = 0; c < NUM_CARDS / 2; c++) begin
            for (int a = 0; a < NUM_CARDS; a++) begin
                if (exp_color[a] == COLOR_W'(c)) begin
                    click_card(a);
                end
            end
        end
        @(negedge clk);
        check_value("status.phase", status.phase, PH_WON);
        check_value("status.pairs", status.pairs, NUM_CARDS / 2);
        check_view();
        click_card(random_bits(IDX_W));
        click_card(random_bits(IDX_W));

        // Let the clock run out
        start_game(random_bits(ADDR_W));
        repeat (TIME_LIMIT * TICKS_PER_SEC + 40) @(posedge clk);
        @(negedge clk);
        exp_phase = PH_LOST;
        check_value("status.phase", status.phase, PH_LOST);
        check_value("status.seconds", status.seconds, TIME_LIMIT);
        click_card(random_bits(IDX_W));
        start_game(random_bits(ADDR_W));

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verif
verilog/game_pkg.sv
verilog/card_board.sv
verilog/game_timer.sv
verilog/game_fsm.sv
verilog/memory_core.sv
verif/tb_memory_core.sv

// ==== Bender.yml ====
package:
  name: memory_core

sources:
  - target: rtl
    files:
      - verilog/game_pkg.sv
      - verilog/card_board.sv
      - verilog/game_timer.sv
      - verilog/game_fsm.sv
      - verilog/memory_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_memory_core.sv
